// ==== verilog.f ====
cpu_pkg.sv
alu.sv
operand_filter.sv
register_file.sv
status_reg.sv
cu.sv
cpu.sv
cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - alu.sv
  - operand_filter.sv
  - register_file.sv
  - status_reg.sv
  - cu.sv
  - cpu.sv
  - target: simulation
    files:
      - cpu_tb.sv

// ==== cpu_tb.sv ====
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int MEM_WORDS = 4096;
  localparam int LIMIT     = 2000;

  logic        clk;
  logic        reset;
  logic        en;
  logic        irq;
  wire  [31:0] data;
  logic [31:0] addr;
  logic        rd;
  logic        wr;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  bit          exp_is_status [$];

  logic [31:0] lfsr;
  int          value_errors;
  int          other_errors;
  int          store_count;
  int          vector_fetches;
  bit          seen_fetch;
  bit          timed_out;

  cpu #(
    .DEPTH       (11),
    .OFFSET_WIDTH(12)
  ) i_cpu (
    .clk  (clk),
    .en   (en),
    .reset(reset),
    .irq  (irq),
    .data (data),
    .addr (addr),
    .rd   (rd),
    .wr   (wr)
  );

  // memory answers within the rd cycle
  assign data = rd ? mem[addr[11:0]] : 'z;

  always @(posedge clk) begin
    if (!reset && wr) begin
      mem[addr[11:0]] <= data;
    end
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w    = {w[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic ir_t reg_form(opcode_e opc, reg_e rd_sel, reg_e ra_sel, reg_e rb_sel,
                                   alu_op_e op);
    ir_t w;
    w                = '0;
    w.opcode         = opc;
    w.rd             = rd_sel;
    w.ra             = ra_sel;
    w.ops.r.rb       = rb_sel;
    w.ops.r.func.op  = op;
    return w;
  endfunction

  function automatic ir_t imm_form(opcode_e opc, reg_e rd_sel, reg_e ra_sel,
                                   logic signed [11:0] imm);
    ir_t w;
    w           = '0;
    w.opcode    = opc;
    w.rd        = rd_sel;
    w.ra        = ra_sel;
    w.ops.i.imm = imm;
    return w;
  endfunction

  task automatic emit(ir_t w);
    prog.push_back(w);
  endtask

  task automatic expect_store(logic [31:0] a, logic [31:0] d, bit is_status);
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_is_status.push_back(is_status);
  endtask

  // reference results, overflow judged on the true signed sum
  task automatic predict_alu(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic cin, output logic [31:0] r, output alu_status_t f);
    longint sa;
    longint sb;
    longint sum;
    int     n;
    sa  = longint'($signed(a));
    sb  = longint'($signed(b));
    n   = int'(b[4:0]);
    f   = '0;
    r   = '0;
    sum = 0;
    case (op)
      ADD, ADC: begin
        sum     = sa + sb + ((op == ADC && cin) ? 1 : 0);
        r       = a + b + ((op == ADC && cin) ? 32'd1 : 32'd0);
        f.carry = ({32'd0, a} + {32'd0, b} + ((op == ADC && cin) ? 64'd1 : 64'd0)) > 64'hffff_ffff;
        f.overflow = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
      end
      SUB: begin
        sum        = sa - sb;
        r          = a - b;
        f.carry    = (a >= b);
        f.overflow = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
      end
      AND:    r = a & b;
      OR:     r = a | b;
      XOR:    r = a ^ b;
      SHL: begin
        r       = a << n;
        f.carry = (n == 0) ? 1'b0 : a[32-n];
      end
      SHR: begin
        r       = a >> n;
        f.carry = (n == 0) ? 1'b0 : a[n-1];
      end
      default: r = b;
    endcase
    f.zero     = (r == 32'd0);
    f.negative = r[31];
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic check_status(string name, status_t got, status_t want);
    if (got !== want) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  task automatic wait_stores(int n);
    int cycles;
    cycles = 0;
    while (!timed_out && store_count < n && cycles < LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!timed_out && store_count < n) begin
      $display("timeout at %0t waiting for store %0d, only %0d seen", $time, n, store_count);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_vector_fetch();
    int cycles;
    cycles = 0;
    while (!timed_out && vector_fetches == 0 && cycles < LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!timed_out && vector_fetches == 0) begin
      $display("timeout at %0t, no fetch from the interrupt vector", $time);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  // bus monitor, compares every write against the store table
  always @(posedge clk) begin
    if (!reset) begin
      if (rd && !seen_fetch) begin
        seen_fetch = 1'b1;
        check_word("addr", addr, PC_RESET);
      end
      if (rd && addr == IRQ_VECTOR) begin
        vector_fetches++;
      end
      if (!en && (rd || wr)) begin
        $display("bus strobe active at %0t while en is low", $time);
        other_errors++;
      end
      if (wr) begin
        if (store_count >= exp_addr.size()) begin
          $display("unexpected store at %0t to address %h", $time, addr);
          other_errors++;
        end else begin
          check_word("addr", addr, exp_addr[store_count]);
          if (exp_is_status[store_count]) begin
            check_status("data", data[5:0], exp_data[store_count][5:0]);
          end else begin
            check_word("data", data, exp_data[store_count]);
          end
        end
        store_count++;
      end
    end
  end

  initial begin
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    alu_status_t f;
    status_t     model;
    alu_op_e     op;
    int          ready;
    reset          = 1'b1;
    en             = 1'b1;
    irq            = 1'b0;
    value_errors   = 0;
    other_errors   = 0;
    store_count    = 0;
    vector_fetches = 0;
    seen_fetch     = 1'b0;
    timed_out      = 1'b0;
    lfsr           = 32'h731b_88e5;
    random_word(x);
    random_word(y);
    model = '0;

    emit(imm_form(LD, R1, ZERO, 12'h700));
    emit(imm_form(LD, R2, ZERO, 12'h701));
    // every op stores its result and then the flags
    for (int k = 0; k < 9; k++) begin
      op = alu_op_e'(k);
      emit(reg_form(ALU, R3, R1, R2, op));
      emit(imm_form(ST, R3, ZERO, 12'(32'h710 + k)));
      emit(imm_form(ST, STATUS, ZERO, 12'(32'h780 + k)));
      predict_alu(op, x, y, model.alu_status.carry, r, f);
      model.alu_status = f;
      expect_store(32'h710 + k, r, 1'b0);
      expect_store(32'h780 + k, 32'(model), 1'b1);
    end
    emit(imm_form(ADDI, R4, R1, -12'sd5));
    emit(imm_form(ST, R4, ZERO, 12'h719));
    emit(imm_form(ST, STATUS, ZERO, 12'h789));
    predict_alu(ADD, x, 32'hffff_fffb, 1'b0, r, f);
    model.alu_status = f;
    expect_store(32'h719, r, 1'b0);
    expect_store(32'h789, 32'(model), 1'b1);

    // equal operands leave carry set for the ADC that follows
    emit(reg_form(ALU, R3, R1, R1, SUB));
    emit(reg_form(ALU, R3, R1, R2, ADC));
    emit(imm_form(ST, R3, ZERO, 12'h71a));
    emit(imm_form(ST, STATUS, ZERO, 12'h78a));
    predict_alu(SUB, x, x, 1'b0, r, f);
    model.alu_status = f;
    predict_alu(ADC, x, y, model.alu_status.carry, r, f);
    model.alu_status = f;
    expect_store(32'h71a, r, 1'b0);
    expect_store(32'h78a, 32'(model), 1'b1);

    // load and store around a base register
    emit(imm_form(ADDI, R5, ZERO, 12'h720));
    emit(imm_form(ST, R1, R5, 12'sd3));
    emit(imm_form(ST, R2, R5, -12'sd2));
    emit(imm_form(LD, R6, R5, 12'sd3));
    emit(imm_form(LD, R7, R5, -12'sd2));
    emit(imm_form(ST, R6, ZERO, 12'h730));
    emit(imm_form(ST, R7, ZERO, 12'h731));
    expect_store(32'h723, x, 1'b0);
    expect_store(32'h71e, y, 1'b0);
    expect_store(32'h730, x, 1'b0);
    expect_store(32'h731, y, 1'b0);

    // taken branch skips the first marker
    emit(reg_form(ALU, R8, R1, R1, SUB));
    emit(imm_form(BEQ, ZERO, ZERO, 12'sd1));
    emit(imm_form(ST, R1, ZERO, 12'h740));
    emit(imm_form(ST, R2, ZERO, 12'h741));
    expect_store(32'h741, y, 1'b0);
    emit(imm_form(ADDI, R9, ZERO, 12'sd1));
    emit(imm_form(BEQ, ZERO, ZERO, 12'sd1));
    emit(imm_form(ST, R1, ZERO, 12'h742));
    emit(imm_form(ST, R2, ZERO, 12'h743));
    expect_store(32'h742, x, 1'b0);
    expect_store(32'h743, y, 1'b0);
    emit(imm_form(JMP, ZERO, ZERO, 12'(prog.size() + 2)));
    emit(imm_form(ST, R1, ZERO, 12'h744));
    emit(imm_form(ST, R2, ZERO, 12'h745));
    expect_store(32'h745, y, 1'b0);

    emit(imm_form(PUSH, R1, ZERO, 12'sd0));
    emit(imm_form(PUSH, R2, ZERO, 12'sd0));
    emit(imm_form(POP, R10, ZERO, 12'sd0));
    emit(imm_form(POP, R9, ZERO, 12'sd0));
    emit(imm_form(ST, R10, ZERO, 12'h750));
    emit(imm_form(ST, R9, ZERO, 12'h751));
    expect_store(SP_RESET - 32'd1, x, 1'b0);
    expect_store(SP_RESET - 32'd2, y, 1'b0);
    expect_store(32'h750, y, 1'b0);
    expect_store(32'h751, x, 1'b0);

    // irq goes high after the ready marker, handler runs after the ADDI
    emit(imm_form(ST, R1, ZERO, 12'h752));
    expect_store(32'h752, x, 1'b0);
    ready = exp_addr.size();
    expect_store(32'h760, x, 1'b0);
    expect_store(32'h761, y, 1'b0);
    // handler sees the ADDI flags with imask set and supervisor mode
    predict_alu(ADD, 32'd0, 32'd7, 1'b0, r, f);
    model.alu_status = f;
    model.imask      = 1'b1;
    model.mode       = SUPERVISOR;
    expect_store(32'h762, 32'(model), 1'b1);
    emit(imm_form(ADDI, R0, ZERO, 12'sd7));
    emit(imm_form(ST, R0, ZERO, 12'h753));
    emit(imm_form(ST, R2, ZERO, 12'h754));
    expect_store(32'h753, 32'd7, 1'b0);
    expect_store(32'h754, y, 1'b0);
    emit(imm_form(ST, R1, ZERO, 12'h755));
    emit(imm_form(ST, R2, ZERO, 12'h756));
    emit(imm_form(ST, R1, ZERO, 12'h757));
    emit(imm_form(HALT, ZERO, ZERO, 12'sd0));
    expect_store(32'h755, x, 1'b0);
    expect_store(32'h756, y, 1'b0);
    expect_store(32'h757, x, 1'b0);

    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {8'hee, 12'(i), 12'(i) ^ 12'hfff};
    end
    for (int i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    mem[12'h700] = x;
    mem[12'h701] = y;
    mem[12'h100] = imm_form(ST, R1, ZERO, 12'h760);
    mem[12'h101] = imm_form(ST, R2, ZERO, 12'h761);
    mem[12'h102] = imm_form(ST, STATUS, ZERO, 12'h762);
    mem[12'h103] = imm_form(RETI, ZERO, ZERO, 12'sd0);

    repeat (5) @(negedge clk);
    reset = 1'b0;

    wait_stores(ready);
    irq = 1'b1;
    wait_vector_fetch();
    irq = 1'b0;
    // second request while imask is set
    wait_stores(ready + 1);
    irq = 1'b1;
    wait_stores(ready + 2);
    irq = 1'b0;
    wait_stores(ready + 5);
    en = 1'b0;
    repeat (8) @(negedge clk);
    en = 1'b1;
    wait_stores(exp_addr.size());
    repeat (20) @(negedge clk);
    if (vector_fetches != 1) begin
      $display("interrupt vector fetched %0d times instead of once", vector_fetches);
      other_errors++;
    end
    finish_run();
  end

endmodule

// ==== cpu.sv ====
module cpu #(
  parameter int DEPTH        = 11,
  parameter int OFFSET_WIDTH = 12
) (
  input  logic        clk,
  input  logic        en,
  input  logic        reset,
  input  logic        irq,
  inout  tri   [31:0] data,
  output logic [31:0] addr,
  output logic        rd,
  output logic        wr
);
  import cpu_pkg::*;

  ctrl_t       ctrl;
  status_t     status;
  alu_status_t alu_status;

  logic [31:0] a_reg_bus;
  logic [31:0] b_reg_bus;
  logic [31:0] a_bus;
  logic [31:0] b_bus;
  logic [31:0] result;
  logic [31:0] wb;

  // external bus, only data stays tri-state
  assign data = wr ? a_bus : 'z;
  assign addr = (rd || wr) ? b_bus : '0;
  assign wb   = ctrl.use_mem ? data : result;

  cu i_cu (
    .clk   (clk),
    .reset (reset),
    .en    (en),
    .irq   (irq),
    .data  (data),
    .status(status),
    .ctrl  (ctrl),
    .rd    (rd),
    .wr    (wr)
  );

  register_file #(
    .DEPTH(DEPTH)
  ) i_register_file (
    .clk        (clk),
    .reset      (reset),
    .sel_a      (ctrl.sel_a),
    .sel_b      (ctrl.sel_b),
    .sel_in     (ctrl.sel_in),
    .ld         (ctrl.ld_reg),
    .in         (wb),
    .post_inc_sp(ctrl.post_inc_sp),
    .pre_dec_sp (ctrl.pre_dec_sp),
    .post_inc_pc(ctrl.post_inc_pc),
    .ld_pc_link (ctrl.ld_pc_link),
    .status     (status),
    .a          (a_reg_bus),
    .b          (b_reg_bus),
    .pc         ()
  );

  status_reg i_status_reg (
    .clk          (clk),
    .reset        (reset),
    .in           (wb[5:0]),
    .ld           (ctrl.ld_reg && ctrl.sel_in == STATUS),
    .alu_status_in(alu_status),
    .ld_alu_status(ctrl.ld_alu_status),
    .imask_in     (ctrl.imask_in),
    .ld_imask     (ctrl.ld_imask),
    .mode_in      (ctrl.mode_in),
    .ld_mode      (ctrl.ld_mode),
    .value        (status)
  );

  // a path carries no offset
  operand_filter #(
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) i_filter_a (
    .in    (a_reg_bus),
    .mask  (ctrl.a_mask),
    .offset('0),
    .out   (a_bus)
  );

  operand_filter #(
    .OFFSET_WIDTH(OFFSET_WIDTH)
  ) i_filter_b (
    .in    (b_reg_bus),
    .mask  (ctrl.b_mask),
    .offset(ctrl.b_offset),
    .out   (b_bus)
  );

  alu i_alu (
    .operation(ctrl.alu_op),
    .carry_in (status.alu_status.carry),
    .a        (a_bus),
    .b        (b_bus),
    .out      (result),
    .status   (alu_status)
  );

endmodule

// ==== cu.sv ====
module cu (
  input  logic             clk,
  input  logic             reset,
  input  logic             en,
  input  logic             irq,
  input  logic [31:0]      data,
  input  cpu_pkg::status_t status,
  output cpu_pkg::ctrl_t   ctrl,
  output logic             rd,
  output logic             wr
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_IRQ,
    S_HALT
  } state_e;

  state_e state;
  state_e next_state;
  state_e end_state;
  ir_t    ir;

  // interrupt is taken between instructions only
  assign end_state = (irq && !status.imask) ? S_IRQ : S_FETCH;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_FETCH;
    end else if (en) begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (en && state == S_FETCH) begin
      ir <= data;
    end
  end

  always_comb begin
    ctrl         = '0;
    ctrl.sel_a   = ZERO;
    ctrl.sel_b   = ZERO;
    ctrl.sel_in  = ZERO;
    ctrl.alu_op  = PASS_B;
    ctrl.mode_in = USER;
    rd           = 1'b0;
    wr           = 1'b0;
    next_state   = state;

    case (state)
      S_FETCH: begin
        rd               = 1'b1;
        ctrl.sel_b       = PC;
        ctrl.b_mask      = '1;
        ctrl.post_inc_pc = 1'b1;
        next_state       = S_DECODE;
      end
      S_DECODE: next_state = S_EXEC;
      S_EXEC: begin
        next_state = end_state;
        case (ir.opcode)
          ALU: begin
            ctrl.sel_a         = ir.ra;
            ctrl.a_mask        = '1;
            ctrl.sel_b         = ir.ops.r.rb;
            ctrl.b_mask        = '1;
            ctrl.alu_op        = ir.ops.r.func.op;
            ctrl.ld_reg        = 1'b1;
            ctrl.sel_in        = ir.rd;
            ctrl.ld_alu_status = 1'b1;
          end
          ADDI: begin
            ctrl.sel_a         = ir.ra;
            ctrl.a_mask        = '1;
            ctrl.b_mask        = '1;
            ctrl.b_offset      = ir.ops.i.imm;
            ctrl.alu_op        = ADD;
            ctrl.ld_reg        = 1'b1;
            ctrl.sel_in        = ir.rd;
            ctrl.ld_alu_status = 1'b1;
          end
          BEQ: begin
            // pc already points past the branch
            if (status.alu_status.zero) begin
              ctrl.sel_b    = PC;
              ctrl.b_mask   = '1;
              ctrl.b_offset = ir.ops.i.imm;
              ctrl.ld_reg   = 1'b1;
              ctrl.sel_in   = PC;
            end
          end
          JMP: begin
            ctrl.sel_b    = ir.ra;
            ctrl.b_mask   = '1;
            ctrl.b_offset = ir.ops.i.imm;
            ctrl.ld_reg   = 1'b1;
            ctrl.sel_in   = PC;
          end
          RETI: begin
            ctrl.sel_b  = LR;
            ctrl.b_mask = '1;
            ctrl.ld_reg = 1'b1;
            ctrl.sel_in = PC;
            next_state  = S_MEM;
          end
          PUSH: begin
            ctrl.pre_dec_sp = 1'b1;
            next_state      = S_MEM;
          end
          LD, ST, POP: next_state = S_MEM;
          HALT: next_state = S_HALT;
          default: ;
        endcase
      end
      S_MEM: begin
        next_state = end_state;
        case (ir.opcode)
          LD: begin
            rd            = 1'b1;
            ctrl.sel_b    = ir.ra;
            ctrl.b_mask   = '1;
            ctrl.b_offset = ir.ops.i.imm;
            ctrl.use_mem  = 1'b1;
            ctrl.ld_reg   = 1'b1;
            ctrl.sel_in   = ir.rd;
          end
          ST: begin
            wr            = 1'b1;
            ctrl.sel_a    = ir.rd;
            ctrl.a_mask   = '1;
            ctrl.sel_b    = ir.ra;
            ctrl.b_mask   = '1;
            ctrl.b_offset = ir.ops.i.imm;
          end
          PUSH: begin
            wr          = 1'b1;
            ctrl.sel_a  = ir.rd;
            ctrl.a_mask = '1;
            ctrl.sel_b  = SP;
            ctrl.b_mask = '1;
          end
          POP: begin
            rd               = 1'b1;
            ctrl.sel_b       = SP;
            ctrl.b_mask      = '1;
            ctrl.use_mem     = 1'b1;
            ctrl.ld_reg      = 1'b1;
            ctrl.sel_in      = ir.rd;
            ctrl.post_inc_sp = 1'b1;
          end
          // imask still set here, so a pending irq waits one instruction
          RETI: ctrl.ld_imask = 1'b1;
          default: ;
        endcase
      end
      S_IRQ: begin
        ctrl.b_mask     = '1;
        ctrl.b_offset   = IRQ_VECTOR[11:0];
        ctrl.ld_reg     = 1'b1;
        ctrl.sel_in     = PC;
        ctrl.ld_pc_link = 1'b1;
        ctrl.imask_in   = 1'b1;
        ctrl.ld_imask   = 1'b1;
        ctrl.mode_in    = SUPERVISOR;
        ctrl.ld_mode    = 1'b1;
        next_state      = S_FETCH;
      end
      S_HALT: ;
      default: next_state = S_FETCH;
    endcase

    // frozen: no strobe may change state
    if (!en) begin
      rd                 = 1'b0;
      wr                 = 1'b0;
      ctrl.ld_reg        = 1'b0;
      ctrl.post_inc_sp   = 1'b0;
      ctrl.pre_dec_sp    = 1'b0;
      ctrl.post_inc_pc   = 1'b0;
      ctrl.ld_pc_link    = 1'b0;
      ctrl.ld_alu_status = 1'b0;
      ctrl.ld_imask      = 1'b0;
      ctrl.ld_mode       = 1'b0;
    end
  end

endmodule

// ==== status_reg.sv ====
module status_reg (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [5:0]           in,
  input  logic                 ld,
  input  cpu_pkg::alu_status_t alu_status_in,
  input  logic                 ld_alu_status,
  input  logic                 imask_in,
  input  logic                 ld_imask,
  input  cpu_pkg::cpu_mode_e   mode_in,
  input  logic                 ld_mode,
  output cpu_pkg::status_t     value
);
  import cpu_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (ld) begin
      value <= status_t'(in);
    end else begin
      // fields load independently
      if (ld_alu_status) begin
        value.alu_status <= alu_status_in;
      end
      if (ld_imask) begin
        value.imask <= imask_in;
      end
      if (ld_mode) begin
        value.mode <= mode_in;
      end
    end
  end

endmodule

// ==== register_file.sv ====
module register_file #(
  parameter int DEPTH = 11
) (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::reg_e    sel_a,
  input  cpu_pkg::reg_e    sel_b,
  input  cpu_pkg::reg_e    sel_in,
  input  logic             ld,
  input  logic [31:0]      in,
  input  logic             post_inc_sp,
  input  logic             pre_dec_sp,
  input  logic             post_inc_pc,
  input  logic             ld_pc_link,
  input  cpu_pkg::status_t status,
  output logic [31:0]      a,
  output logic [31:0]      b,
  output logic [31:0]      pc
);
  import cpu_pkg::*;

  logic [31:0] gpr [DEPTH];
  logic [31:0] sp;
  logic [31:0] lr;
  logic [31:0] pc_q;

  function automatic logic [31:0] read_reg(reg_e sel);
    logic [31:0] v;
    case (sel)
      SP:     v = sp;
      LR:     v = lr;
      PC:     v = pc_q;
      STATUS: v = 32'(status);
      ZERO:   v = '0;
      default: begin
        if (int'(sel) < DEPTH) begin
          v = gpr[sel];
        end else begin
          v = '0;
        end
      end
    endcase
    return v;
  endfunction

  always_comb begin
    a = read_reg(sel_a);
    b = read_reg(sel_b);
  end

  assign pc = pc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        gpr[i] <= '0;
      end
    end else if (ld && int'(sel_in) < DEPTH) begin
      gpr[sel_in] <= in;
    end
  end

  // a direct load wins over the stepping strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      sp <= SP_RESET;
    end else if (ld && sel_in == SP) begin
      sp <= in;
    end else if (pre_dec_sp) begin
      sp <= sp - 32'd1;
    end else if (post_inc_sp) begin
      sp <= sp + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lr <= '0;
    end else if (ld && sel_in == LR) begin
      lr <= in;
    end else if (ld_pc_link) begin
      lr <= pc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= PC_RESET;
    end else if (ld && sel_in == PC) begin
      pc_q <= in;
    end else if (post_inc_pc) begin
      pc_q <= pc_q + 32'd1;
    end
  end

endmodule

// ==== operand_filter.sv ====
module operand_filter #(
  parameter int OFFSET_WIDTH = 12
) (
  input  logic [31:0]                    in,
  input  logic [31:0]                    mask,
  input  logic signed [OFFSET_WIDTH-1:0] offset,
  output logic [31:0]                    out
);

  logic [31:0] masked;
  logic [31:0] offset_ext;

  assign masked = in & mask;

  // sign extend to the full bus width
  assign offset_ext = {{(32 - OFFSET_WIDTH){offset[OFFSET_WIDTH-1]}}, offset};

  assign out = masked + offset_ext;

endmodule

// ==== alu.sv ====
module alu (
  input  cpu_pkg::alu_op_e     operation,
  input  logic                 carry_in,
  input  logic [31:0]          a,
  input  logic [31:0]          b,
  output logic [31:0]          out,
  output cpu_pkg::alu_status_t status
);
  import cpu_pkg::*;

  logic [32:0] wide;
  logic        carry;
  logic        overflow;

  always_comb begin
    wide     = '0;
    out      = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    case (operation)
      ADD, ADC: begin
        wide     = {1'b0, a} + {1'b0, b} + 33'(operation == ADC && carry_in);
        out      = wide[31:0];
        carry    = wide[32];
        overflow = (a[31] == b[31]) && (out[31] != a[31]);
      end
      SUB: begin
        // carry set means no borrow
        wide     = {1'b0, a} + {1'b0, ~b} + 33'd1;
        out      = wide[31:0];
        carry    = wide[32];
        overflow = (a[31] != b[31]) && (out[31] != a[31]);
      end
      AND: out = a & b;
      OR:  out = a | b;
      XOR: out = a ^ b;
      SHL: begin
        wide  = {1'b0, a} << b[4:0];
        out   = wide[31:0];
        carry = wide[32];
      end
      SHR: begin
        wide  = {a, 1'b0} >> b[4:0];
        out   = wide[32:1];
        carry = wide[0];
      end
      PASS_B: out = b;
      default: out = '0;
    endcase
  end

  assign status.carry    = carry;
  assign status.zero     = (out == '0);
  assign status.negative = out[31];
  assign status.overflow = overflow;

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

  // register selector, codes 0 to 10 are the general registers
  typedef enum logic [3:0] {
    R0, R1, R2, R3, R4, R5, R6, R7, R8, R9, R10,
    SP,
    LR,
    PC,
    STATUS,
    ZERO
  } reg_e;

  typedef enum logic [3:0] {
    ADD, ADC, SUB, AND, OR, XOR, SHL, SHR, PASS_B
  } alu_op_e;

  typedef enum logic [5:0] {
    ALU, ADDI, LD, ST, BEQ, JMP, PUSH, POP, RETI, HALT
  } opcode_e;

  typedef struct packed {
    logic [1:0] pad;
    alu_op_e    op;
  } func_t;

  // register form, rb and func share the low bits with imm
  typedef struct packed {
    reg_e       rb;
    func_t      func;
    logic [7:0] unused;
  } ir_reg_t;

  typedef struct packed {
    logic [5:0]         unused;
    logic signed [11:0] imm;
  } ir_imm_t;

  typedef union packed {
    ir_reg_t r;
    ir_imm_t i;
  } ir_ops_u;

  // ST and PUSH take their source from rd, POP and LD write rd
  typedef struct packed {
    opcode_e opcode;
    reg_e    rd;
    reg_e    ra;
    ir_ops_u ops;
  } ir_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic negative;
    logic overflow;
  } alu_status_t;

  typedef enum logic {
    USER,
    SUPERVISOR
  } cpu_mode_e;

  typedef struct packed {
    alu_status_t alu_status;
    logic        imask;
    cpu_mode_e   mode;
  } status_t;

  typedef struct packed {
    reg_e               sel_a;
    reg_e               sel_b;
    reg_e               sel_in;
    logic               ld_reg;
    logic [31:0]        a_mask;
    logic [31:0]        b_mask;
    logic signed [11:0] b_offset;
    alu_op_e            alu_op;
    logic               use_mem;
    logic               post_inc_sp;
    logic               pre_dec_sp;
    logic               post_inc_pc;
    logic               ld_pc_link;
    logic               ld_alu_status;
    logic               imask_in;
    logic               ld_imask;
    cpu_mode_e          mode_in;
    logic               ld_mode;
  } ctrl_t;

  localparam logic [31:0] SP_RESET   = 32'h0000_0ff0;
  localparam logic [31:0] IRQ_VECTOR = 32'h0000_0100;
  localparam logic [31:0] PC_RESET   = 32'h0000_0000;

endpackage
